//--- cache_core.f
+incdir+common
common/cache_pkg.sv
src/sync_ram.sv
cache/cache_way.sv
cache/cache_ctrl.sv
cache/cache_core.sv
bench/mem_model.sv
bench/cache_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets"
	@echo "  test   build the cache testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f cache_core.f --top-module cache_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vcache_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

//--- bench/cache_tb.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_tb;
    import cache_pkg::*;

    // about 35 accesses of at most about 40 cycles each
    localparam int          TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] ADDR_A = 32'h0001_2344;
    localparam logic [31:0] ADDR_B = 32'h0034_5678;
    localparam logic [31:0] ADDR_C = 32'h00ab_cde0;

    logic        clk;
    logic        resetn;
    logic        req_valid;
    cpu_req_t    req;
    logic        req_ready;
    logic        resp_valid;
    word_t       resp_data;
    logic        resp_ready;
    logic        rd_valid;
    logic [31:0] rd_addr;
    logic        rd_ready;
    logic        ret_valid;
    logic        ret_last;
    word_t       ret_data;
    logic        wr_valid;
    mem_wr_req_t wr_req;
    logic        wr_ready;
    int          wb_count;
    int          rd_count = 0;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    logic [31:0] cur_addr = '0;
    logic [31:0] wb_addr = '0;

    // expected memory by word address
    word_t ref_mem [logic [29:0]];

    cache_core dut (
        .clk        (clk),
        .resetn     (resetn),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_ready (resp_ready),
        .rd_valid   (rd_valid),
        .rd_addr    (rd_addr),
        .rd_ready   (rd_ready),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .ret_data   (ret_data),
        .wr_valid   (wr_valid),
        .wr_req     (wr_req),
        .wr_ready   (wr_ready)
    );

    mem_model mem (
        .clk       (clk),
        .resetn    (resetn),
        .rd_valid  (rd_valid),
        .rd_addr   (rd_addr),
        .rd_ready  (rd_ready),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_valid  (wr_valid),
        .wr_req    (wr_req),
        .wr_ready  (wr_ready),
        .wb_count  (wb_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // memory handshakes complete at the next rising edge
    always @(negedge clk) begin
        if (resetn && rd_valid && rd_ready) begin
            rd_count <= rd_count + 1;
            check_addr(rd_addr, {cur_addr[31:4], 4'h0}, "line read address");
        end
        if (resetn && wr_valid && wr_ready) begin
            wb_addr <= wr_req.addr;
        end
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // power-up memory contents
    function automatic word_t fill_word(logic [31:0] addr);
        logic [31:0] s;
        s = {addr[31:2], 2'b00} ^ 32'h1645;
        for (int i = 0; i < 16; i++) begin
            s = lfsr_next(s);
        end
        return s;
    endfunction

    function automatic word_t expected_word(logic [31:0] addr);
        if (ref_mem.exists(addr[31:2])) begin
            return ref_mem[addr[31:2]];
        end
        return fill_word(addr);
    endfunction

    task automatic apply_store(logic [31:0] addr, logic [3:0] wstrb, word_t wdata);
        word_t w;
        w = expected_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                w[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        ref_mem[addr[31:2]] = w;
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(logic [31:0] got, logic [31:0] exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // one request whose response is held for hold cycles
    task automatic cpu_access(input logic write, input logic [31:0] addr,
                              input logic [3:0] wstrb, input word_t wdata,
                              input int hold, output word_t data, output int lat);
        cpu_req_t r;
        r.write  = write;
        r.tag    = addr[31 -: `CACHE_TAG_W];
        r.index  = addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
        r.offset = addr[`CACHE_OFFSET_W-1:0];
        r.wstrb  = wstrb;
        r.wdata  = wdata;
        cur_addr = addr;
        @(posedge clk);
        req_valid  <= 1'b1;
        req        <= r;
        resp_ready <= (hold == 0);
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        lat = 0;
        @(negedge clk);
        while (!resp_valid) begin
            @(negedge clk);
            lat++;
        end
        data = resp_data;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_flag(resp_valid, 1'b1, "resp_valid under back-pressure");
            check_word(resp_data, data, "resp_data under back-pressure");
        end
        if (hold > 0) begin
            @(posedge clk);
            resp_ready <= 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic read_word(input logic [31:0] addr, input int hold, output int lat);
        word_t d;
        cpu_access(1'b0, addr, 4'h0, '0, hold, d, lat);
        check_word(d, expected_word(addr), $sformatf("read %h", addr));
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [3:0] wstrb,
                              input word_t wdata, output int lat);
        word_t d;
        apply_store(addr, wstrb, wdata);
        cpu_access(1'b1, addr, wstrb, wdata, 0, d, lat);
        check_word(d, expected_word(addr), $sformatf("write %h", addr));
    endtask

    task automatic after_reset();
        int lat;
        int rd0;
        @(negedge clk);
        check_flag(req_ready, 1'b1, "req_ready after reset");
        check_flag(resp_valid, 1'b0, "resp_valid after reset");
        check_flag(rd_valid, 1'b0, "rd_valid after reset");
        check_flag(wr_valid, 1'b0, "wr_valid after reset");
        rd0 = rd_count;
        read_word(ADDR_A, 0, lat);
        check_count(rd_count - rd0, 1, "memory reads for a cold read");
    endtask

    task automatic hit_without_refill();
        int lat;
        int rd0;
        rd0 = rd_count;
        read_word(ADDR_A + 32'h4, 0, lat);
        check_count(lat, 2, "read hit latency");
        check_count(rd_count - rd0, 0, "memory reads on a hit");
    endtask

    task automatic partial_write_hit();
        int lat;
        write_word(ADDR_A, 4'b0101, 32'hdead_beef, lat);
        check_count(lat, 2, "write hit latency");
        read_word(ADDR_A, 0, lat);
    endtask

    task automatic write_miss_fill();
        int lat;
        int rd0;
        rd0 = rd_count;
        write_word(ADDR_B, 4'b1100, 32'h1234_5678, lat);
        check_count(rd_count - rd0, 1, "memory reads on a write miss");
        for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
            read_word({ADDR_B[31:4], w[1:0], 2'b00}, 0, lat);
        end
    endtask

    // other tags at line B's set until the dirty line leaves
    task automatic dirty_eviction();
        int          lat;
        int          wb0;
        int          k;
        logic [31:0] a;
        wb0 = wb_count;
        k = 1;
        while (wb_count == wb0 && k <= 16) begin
            a = {ADDR_B[31:4], 4'h0} + k * 32'h1000;
            read_word(a, 0, lat);
            k++;
        end
        check_count(wb_count - wb0, 1, "write-backs while evicting");
        check_addr(wb_addr, {ADDR_B[31:4], 4'h0}, "write-back address");
        for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
            a = {ADDR_B[31:4], w[1:0], 2'b00};
            check_word(mem.peek_word(a), expected_word(a), $sformatf("memory at %h", a));
            read_word(a, 0, lat);
        end
    endtask

    task automatic held_response();
        int lat;
        read_word(ADDR_A, 5, lat);
        read_word(ADDR_C, 4, lat);
    endtask

    initial begin
        resetn     = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        after_reset();
        hit_without_refill();
        partial_write_hit();
        write_miss_fill();
        dirty_eviction();
        held_response();
        $display("summary %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- bench/mem_model.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module mem_model (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   rd_valid,
    input  logic [31:0]            rd_addr,
    output logic                   rd_ready,
    output logic                   ret_valid,
    output logic                   ret_last,
    output cache_pkg::word_t       ret_data,
    input  logic                   wr_valid,
    input  cache_pkg::mem_wr_req_t wr_req,
    output logic                   wr_ready,
    output int                     wb_count
);
    import cache_pkg::*;

    // only lines that were written back are stored
    line_t       lines [logic [27:0]];
    logic [31:0] rnd;
    logic        busy;
    logic [27:0] rd_line;
    int          delay;
    int          beat;

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // power-up contents mixed from the word address
    function automatic word_t fill_word(logic [31:0] addr);
        logic [31:0] s;
        s = {addr[31:2], 2'b00} ^ 32'h1645;
        for (int i = 0; i < 16; i++) begin
            s = lfsr_next(s);
        end
        return s;
    endfunction

    function automatic line_t read_line(logic [27:0] key);
        line_t l;
        if (lines.exists(key)) begin
            return lines[key];
        end
        for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
            l[w*32 +: 32] = fill_word({key, w[1:0], 2'b00});
        end
        return l;
    endfunction

    function automatic word_t peek_word(logic [31:0] addr);
        line_t l;
        l = read_line(addr[31:4]);
        return l[addr[3:2]*32 +: 32];
    endfunction

    // one bit per call
    function automatic logic take_bit();
        logic b;
        b = rnd[0];
        rnd = lfsr_next(rnd);
        return b;
    endfunction

    initial begin
        rnd       = 32'h1645;
        rd_ready  = 1'b0;
        wr_ready  = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wb_count  = 0;
        busy      = 1'b0;
    end

    always @(posedge clk) begin
        line_t l;
        if (!resetn) begin
            rnd = 32'h1645;
            rd_ready  <= 1'b0;
            wr_ready  <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            ret_data  <= '0;
            wb_count  <= 0;
            busy      <= 1'b0;
            delay     <= 0;
            beat      <= 0;
        end else begin
            rd_ready  <= 1'b0;
            wr_ready  <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            // each request waits one cycle for ready
            if (wr_valid && !wr_ready) begin
                wr_ready <= 1'b1;
            end
            if (wr_valid && wr_ready) begin
                lines[wr_req.addr[31:4]] = wr_req.line;
                wb_count <= wb_count + 1;
            end
            if (rd_valid && !rd_ready && !busy) begin
                rd_ready <= 1'b1;
            end
            if (rd_valid && rd_ready) begin
                rd_line <= rd_addr[31:4];
                busy    <= 1'b1;
                delay   <= 3;
                beat    <= 0;
            end else if (busy) begin
                if (delay > 0) begin
                    delay <= delay - 1;
                end else if (!take_bit()) begin
                    // a set bit leaves a gap
                    l = read_line(rd_line);
                    ret_valid <= 1'b1;
                    ret_data  <= l[beat*32 +: 32];
                    ret_last  <= (beat == 3);
                    beat      <= beat + 1;
                    if (beat == 3) begin
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

//--- cache/cache_core.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_core (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    req_valid,
    input  cache_pkg::cpu_req_t     req,
    output logic                    req_ready,
    output logic                    resp_valid,
    output cache_pkg::word_t        resp_data,
    input  logic                    resp_ready,
    output logic                    rd_valid,
    output logic [31:0]             rd_addr,
    input  logic                    rd_ready,
    input  logic                    ret_valid,
    input  logic                    ret_last,
    input  cache_pkg::word_t        ret_data,
    output logic                    wr_valid,
    output cache_pkg::mem_wr_req_t  wr_req,
    input  logic                    wr_ready
);
    import cache_pkg::*;

    logic [`CACHE_INDEX_W-1:0] way_index;
    logic [`CACHE_TAG_W-1:0]   way_tag;
    logic [1:0]                way_we;
    tag_entry_t                way_entry;
    line_t                     way_line;
    logic [1:0]                way_hit;
    tag_entry_t                way_entry_rd [2];
    line_t                     way_line_rd [2];

    cache_ctrl u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data),
        .resp_ready   (resp_ready),
        .rd_valid     (rd_valid),
        .rd_addr      (rd_addr),
        .rd_ready     (rd_ready),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .ret_data     (ret_data),
        .wr_valid     (wr_valid),
        .wr_req       (wr_req),
        .wr_ready     (wr_ready),
        .way_index    (way_index),
        .way_tag      (way_tag),
        .way_we       (way_we),
        .way_entry    (way_entry),
        .way_line     (way_line),
        .way_hit      (way_hit),
        .way_entry_rd (way_entry_rd),
        .way_line_rd  (way_line_rd)
    );

    // both ways share index, tag and write data
    for (genvar w = 0; w < 2; w++) begin : g_way
        cache_way u_way (
            .clk        (clk),
            .resetn     (resetn),
            .rd_index   (way_index),
            .lookup_tag (way_tag),
            .we         (way_we[w]),
            .wr_entry   (way_entry),
            .wr_line    (way_line),
            .hit        (way_hit[w]),
            .entry      (way_entry_rd[w]),
            .line       (way_line_rd[w])
        );
    end

endmodule

//--- cache/cache_ctrl.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_ctrl (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       req_valid,
    input  cache_pkg::cpu_req_t        req,
    output logic                       req_ready,
    output logic                       resp_valid,
    output cache_pkg::word_t           resp_data,
    input  logic                       resp_ready,
    output logic                       rd_valid,
    output logic [31:0]                rd_addr,
    input  logic                       rd_ready,
    input  logic                       ret_valid,
    input  logic                       ret_last,
    input  cache_pkg::word_t           ret_data,
    output logic                       wr_valid,
    output cache_pkg::mem_wr_req_t     wr_req,
    input  logic                       wr_ready,
    output logic [`CACHE_INDEX_W-1:0]  way_index,
    output logic [`CACHE_TAG_W-1:0]    way_tag,
    output logic [1:0]                 way_we,
    output cache_pkg::tag_entry_t      way_entry,
    output cache_pkg::line_t           way_line,
    input  logic [1:0]                 way_hit,
    input  cache_pkg::tag_entry_t      way_entry_rd [2],
    input  cache_pkg::line_t           way_line_rd [2]
);
    import cache_pkg::*;

    localparam int WW = `CACHE_WORD_W;
    localparam int OW = `CACHE_OFFSET_W;

    cache_state_e                      state;
    cache_state_e                      state_next;
    logic [22:0]                       lfsr;
    logic [$clog2(`CACHE_LINE_WORDS)-1:0] beat_cnt;
    cpu_req_t                          req_q;
    logic                              hit_q;
    logic                              way_sel_q;
    logic [`CACHE_TAG_W-1:0]           victim_tag_q;
    line_t                             line_q;
    line_t                             fill_q;
    line_t                             fill_line;
    line_t                             merged;
    logic                              lookup_way;
    tag_entry_t                        victim_entry;

    // apply the store bytes to one word of a line
    function automatic line_t merge_line(line_t base, cpu_req_t r);
        line_t res;
        res = base;
        if (r.write) begin
            for (int b = 0; b < WW / 8; b++) begin
                if (r.wstrb[b]) begin
                    res[r.offset[OW-1:2]*WW + b*8 +: 8] = r.wdata[b*8 +: 8];
                end
            end
        end
        return res;
    endfunction

    assign victim_entry = way_entry_rd[lfsr[0]];
    assign lookup_way   = (|way_hit) ? way_hit[1] : lfsr[0];

    always_comb begin
        fill_line = fill_q;
        fill_line[beat_cnt*WW +: WW] = ret_data;
    end

    assign merged = merge_line((state == REFILL) ? fill_line : line_q, req_q);

    always_comb begin
        state_next = state;
        case (state)
            IDLE:
                if (req_valid)
                    state_next = LOOKUP;
            LOOKUP:
                if (|way_hit)
                    state_next = RESPOND;
                else if (victim_entry.valid && victim_entry.dirty)
                    state_next = WRITEBACK;
                else
                    state_next = REFILL_REQ;
            WRITEBACK:
                if (wr_ready)
                    state_next = REFILL_REQ;
            REFILL_REQ:
                if (rd_ready)
                    state_next = REFILL;
            REFILL:
                if (ret_valid && ret_last)
                    state_next = RESPOND;
            RESPOND:
                if (resp_valid && resp_ready)
                    state_next = IDLE;
            default:
                state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= IDLE;
            resp_valid <= 1'b0;
            beat_cnt   <= '0;
            lfsr       <= `CACHE_LFSR_SEED;
        end else begin
            state <= state_next;
            lfsr  <= {lfsr[21:0], lfsr[22] ^ lfsr[17]};
            if (state == RESPOND && !resp_valid) begin
                resp_valid <= 1'b1;
            end else if (resp_valid && resp_ready) begin
                resp_valid <= 1'b0;
            end
            if (state == REFILL_REQ) begin
                beat_cnt <= '0;
            end else if (state == REFILL && ret_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
        // hit line, or the victim for write-back
        if (state == LOOKUP) begin
            hit_q        <= |way_hit;
            way_sel_q    <= lookup_way;
            line_q       <= way_line_rd[lookup_way];
            victim_tag_q <= victim_entry.tag;
        end
        if (state == REFILL && ret_valid) begin
            fill_q <= fill_line;
            if (ret_last) begin
                line_q <= merged;
            end
        end
        if (state == RESPOND && !resp_valid) begin
            line_q <= merged;
        end
    end

    assign req_ready = (state == IDLE);
    assign resp_data = line_q[req_q.offset[OW-1:2]*WW +: WW];

    assign wr_valid    = (state == WRITEBACK);
    assign wr_req.addr = {victim_tag_q, req_q.index, {OW{1'b0}}};
    assign wr_req.line = line_q;
    assign rd_valid    = (state == REFILL_REQ);
    assign rd_addr     = {req_q.tag, req_q.index, {OW{1'b0}}};

    always_comb begin
        way_index       = (state == IDLE) ? req.index : req_q.index;
        way_tag         = req_q.tag;
        way_line        = merged;
        way_entry.valid = 1'b1;
        way_entry.dirty = req_q.write;
        way_entry.tag   = req_q.tag;
        way_we          = '0;
        // refill lands on the last beat, a store hit one cycle after lookup
        if (state == REFILL && ret_valid && ret_last) begin
            way_we[way_sel_q] = 1'b1;
        end
        if (state == RESPOND && !resp_valid && hit_q && req_q.write) begin
            way_we[way_sel_q] = 1'b1;
        end
    end

    a_hit_onehot: assert property (@(posedge clk) disable iff (!resetn)
        state == LOOKUP |-> !(way_hit[0] && way_hit[1]));

    a_wr_stable: assert property (@(posedge clk) disable iff (!resetn)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr_req));

    a_rd_stable: assert property (@(posedge clk) disable iff (!resetn)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_addr));

endmodule

//--- cache/cache_way.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_way (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic [`CACHE_INDEX_W-1:0]  rd_index,
    input  logic [`CACHE_TAG_W-1:0]    lookup_tag,
    input  logic                       we,
    input  cache_pkg::tag_entry_t      wr_entry,
    input  cache_pkg::line_t           wr_line,
    output logic                       hit,
    output cache_pkg::tag_entry_t      entry,
    output cache_pkg::line_t           line
);
    import cache_pkg::*;

    localparam int SETS = 1 << `CACHE_INDEX_W;

    typedef logic [`CACHE_TAG_W-1:0] tag_t;

    logic [SETS-1:0]           valid_q;
    logic [SETS-1:0]           dirty_q;
    logic [`CACHE_INDEX_W-1:0] index_q;
    tag_t                      tag_rd;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (we) begin
            valid_q[rd_index] <= wr_entry.valid;
            dirty_q[rd_index] <= wr_entry.dirty;
        end
    end

    // same delay as the ram read
    always_ff @(posedge clk) begin
        index_q <= rd_index;
    end

    sync_ram #(.ram_t(tag_t), .DEPTH(SETS)) u_tag_ram (
        .clk   (clk),
        .we    (we),
        .addr  (rd_index),
        .wdata (wr_entry.tag),
        .rdata (tag_rd)
    );

    sync_ram #(.ram_t(line_t), .DEPTH(SETS)) u_data_ram (
        .clk   (clk),
        .we    (we),
        .addr  (rd_index),
        .wdata (wr_line),
        .rdata (line)
    );

    always_comb begin
        entry.valid = valid_q[index_q];
        entry.dirty = dirty_q[index_q];
        entry.tag   = tag_rd;
    end

    assign hit = entry.valid && (entry.tag == lookup_tag);

endmodule

//--- src/sync_ram.sv
`timescale 1ns/10ps

module sync_ram #(
    parameter type ram_t = logic [31:0],
    parameter int  DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  ram_t                     wdata,
    output ram_t                     rdata
);

    ram_t mem [DEPTH];

    // read returns the old contents on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

//--- common/cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

    typedef logic [`CACHE_WORD_W-1:0] word_t;
    typedef logic [`CACHE_LINE_WORDS*`CACHE_WORD_W-1:0] line_t;

    // one processor access
    typedef struct packed {
        logic                        write;
        logic [`CACHE_TAG_W-1:0]     tag;
        logic [`CACHE_INDEX_W-1:0]   index;
        logic [`CACHE_OFFSET_W-1:0]  offset;
        logic [`CACHE_WORD_W/8-1:0]  wstrb;
        word_t                       wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                    valid;
        logic                    dirty;
        logic [`CACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    // dirty line going back to memory
    typedef struct packed {
        logic [31:0] addr;
        line_t       line;
    } mem_wr_req_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL_REQ,
        REFILL,
        RESPOND
    } cache_state_e;

endpackage

//--- common/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// address split, tag | index | offset
`define CACHE_INDEX_W    8
`define CACHE_TAG_W      20
`define CACHE_OFFSET_W   4

`define CACHE_WORD_W     32
`define CACHE_LINE_WORDS 4

// victim lfsr start value
`define CACHE_LFSR_SEED  23'b100_1010_0101_0010_1000_1010

`endif
